// ==== tb/execStageTb.sv ====
`timescale 1ns/10ps

`include "alu_macros.svh"

module execStageTb import aluPkg::*; ();

    typedef struct {
        functT funct;
        wordT  a;
        wordT  b;
        shamtT shamt;
        wordT  result;
        logic  writeEn, carry, ovf, negative, zero, illegal;
    } rowT;

    logic  clk = 1'b0;
    logic  rst, valid;
    functT funct;
    wordT  a, b;
    shamtT shamt;
    logic  resultValid, writeEnable, carry, overflow, negative, zero, illegalOp;
    wordT  result;

    rowT    rows[$];              // Stimulus and expected values
    integer seed = 32'h921c_d021;
    int     passCount = 0;
    int     failCount = 0;
    int     errors;               // Per test
    bit     tableReady = 1'b0;

    execStage DUT (.*);

    always #20 clk = ~clk;  // 40 ns period

    // Negative and zero follow from the expected result
    task automatic addRow(input functT f, input wordT opA, input wordT opB, input shamtT s,
                          input wordT r, input logic we, input logic c, input logic v,
                          input logic il);
        rows.push_back('{f, opA, opB, s, r, we, c, v, r[31], !il && (r == '0), il});
    endtask

    // 33-bit model for the add and subtract family
    task automatic addArith(input functT f, input wordT opA, input wordT opB);
        logic [32:0]        wide;
        logic signed [32:0] exact;  // Signed result with one extra bit
        logic               isAdd;
        logic               ovf;
        isAdd = (f == `FN_ADD) || (f == `FN_ADDU);
        wide  = isAdd ? {1'b0, opA} + {1'b0, opB} : {1'b0, opA} - {1'b0, opB};
        exact = isAdd ? $signed({opA[31], opA}) + $signed({opB[31], opB})
                      : $signed({opA[31], opA}) - $signed({opB[31], opB});
        ovf   = (exact[32] != exact[31]);  // Does not fit in 32 signed bits
        addRow(f, opA, opB, 5'd0, wide[31:0], 1'b1, isAdd ? wide[32] : (opA < opB), ovf, 1'b0);
    endtask

    task automatic buildTable();
        functT arithCodes[4] = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU};
        addRow(`FN_AND,  32'hf0f0_1234, 32'h0ff0_ff00, 5'd0, 32'h00f0_1200, 1, 0, 0, 0);
        addRow(`FN_OR,   32'hf0f0_1234, 32'h0ff0_ff00, 5'd0, 32'hfff0_ff34, 1, 0, 0, 0);
        addRow(`FN_XOR,  32'hf0f0_1234, 32'h0ff0_ff00, 5'd0, 32'hff00_ed34, 1, 0, 0, 0);
        addRow(`FN_NOR,  32'hf0f0_1234, 32'h0ff0_ff00, 5'd0, 32'h000f_00cb, 1, 0, 0, 0);
        addRow(`FN_SLT,  32'hffff_fffe, 32'h0000_0001, 5'd0, 32'h0000_0001, 1, 0, 0, 0);
        addRow(`FN_SLTU, 32'hffff_fffe, 32'h0000_0001, 5'd0, 32'h0000_0000, 1, 0, 0, 0);
        addRow(`FN_SLT,  32'h0000_0001, 32'h8000_0000, 5'd0, 32'h0000_0000, 1, 0, 0, 0);
        addRow(`FN_SLTU, 32'h0000_0001, 32'h8000_0000, 5'd0, 32'h0000_0001, 1, 0, 0, 0);
        addRow(`FN_ADD,  32'h7fff_ffff, 32'h0000_0001, 5'd0, 32'h8000_0000, 1, 0, 1, 0);
        addRow(`FN_SUB,  32'h0000_0000, 32'h0000_0001, 5'd0, 32'hffff_ffff, 1, 1, 0, 0);
        addRow(`FN_SUBU, 32'h0000_0005, 32'h0000_0005, 5'd0, 32'h0000_0000, 1, 0, 0, 0);
        addRow(`FN_ADDU, 32'hffff_ffff, 32'h0000_0001, 5'd0, 32'h0000_0000, 1, 1, 0, 0);
        addRow(`FN_SUB,  32'h8000_0000, 32'h0000_0001, 5'd0, 32'h7fff_ffff, 1, 0, 1, 0);
        // Fixed shifts ignore a, variable shifts ignore shamt
        addRow(`FN_SLL,  32'h0000_0003, 32'h0000_0001, 5'd31, 32'h8000_0000, 1, 0, 0, 0);
        addRow(`FN_SLL,  32'h0000_0003, 32'h1234_5678, 5'd0, 32'h1234_5678, 1, 0, 0, 0);
        addRow(`FN_SRL,  32'h0000_0000, 32'h8000_0000, 5'd31, 32'h0000_0001, 1, 0, 0, 0);
        addRow(`FN_SRA,  32'h0000_0000, 32'h8000_0000, 5'd4, 32'hf800_0000, 1, 0, 0, 0);
        addRow(`FN_SLLV, 32'hffff_ffe4, 32'h0000_00ff, 5'd3, 32'h0000_0ff0, 1, 0, 0, 0);
        addRow(`FN_SRLV, 32'h0000_001f, 32'hffff_ffff, 5'd0, 32'h0000_0001, 1, 0, 0, 0);
        addRow(`FN_SRAV, 32'h0000_0008, 32'h8765_4321, 5'd1, 32'hff87_6543, 1, 0, 0, 0);
        addRow(`FN_CLZ,  32'h0000_0000, 32'h0000_0000, 5'd0, 32'h0000_0020, 1, 0, 0, 0);
        addRow(`FN_CLO,  32'hffff_ffff, 32'h0000_0000, 5'd0, 32'h0000_0020, 1, 0, 0, 0);
        addRow(`FN_CLZ,  32'h0001_0000, 32'h0000_0000, 5'd0, 32'h0000_000f, 1, 0, 0, 0);
        addRow(`FN_CLO,  32'hfffe_ffff, 32'h0000_0000, 5'd0, 32'h0000_000f, 1, 0, 0, 0);
        addRow(`FN_CLZ,  32'h8000_0000, 32'h0000_0000, 5'd0, 32'h0000_0000, 1, 0, 0, 0);
        addRow(`FN_MOVZ, 32'hcafe_f00d, 32'h0000_0000, 5'd0, 32'hcafe_f00d, 1, 0, 0, 0);
        addRow(`FN_MOVZ, 32'hcafe_f00d, 32'h0000_0001, 5'd0, 32'hcafe_f00d, 0, 0, 0, 0);
        addRow(`FN_MOVN, 32'h0000_0000, 32'h0000_0003, 5'd0, 32'h0000_0000, 1, 0, 0, 0);
        addRow(`FN_MOVN, 32'h0000_1234, 32'h0000_0000, 5'd0, 32'h0000_1234, 0, 0, 0, 0);
        addRow(6'b111111, 32'hffff_ffff, 32'hffff_ffff, 5'd7, 32'h0000_0000, 0, 0, 0, 1);
        addRow(6'b000001, 32'h8000_0000, 32'h8000_0000, 5'd0, 32'h0000_0000, 0, 0, 0, 1);
        for (int i = 0; i < 200; i++)
        begin
            addArith(arithCodes[{$random(seed)} % 4], $random(seed), $random(seed));
        end
    endtask

    task automatic checkField(input string name, input wordT expVal, input wordT actVal);
        assert (expVal === actVal)
        else
        begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
            errors++;
        end
    endtask

    task automatic finishTest(input string label);
        if (errors == 0)
        begin
            passCount++;
            $display("Test %s: pass", label);
        end
        else
        begin
            failCount++;
            $display("Test %s: FAIL with %0d errors", label, errors);
        end
    endtask

    // Nothing may come out during reset or an idle cycle
    task automatic checkQuiet(input string label);
        errors = 0;
        checkField("resultValid", 1'b0, resultValid);
        checkField("writeEnable", 1'b0, writeEnable);
        finishTest(label);
    endtask

    task automatic checkRow(input int idx);
        rowT row;
        row    = rows[idx];
        errors = 0;
        assert (resultValid === 1'b1)
        else
        begin
            $display("At %0t the result of row %0d did not arrive one cycle after valid",
                     $time, idx);
            errors++;
        end
        checkField("result", row.result, result);
        checkField("writeEnable", row.writeEn, writeEnable);
        checkField("carry", row.carry, carry);
        checkField("overflow", row.ovf, overflow);
        checkField("negative", row.negative, negative);
        checkField("zero", row.zero, zero);
        checkField("illegalOp", row.illegal, illegalOp);
        finishTest($sformatf("%0d funct %b", idx, row.funct));
    endtask

    initial
    begin
        rst   = 1'b1;
        valid = 1'b1;  // Must be ignored while in reset
        funct = '0;
        a     = '0;
        b     = '0;
        shamt = '0;
        buildTable();
        tableReady = 1'b1;
        @(posedge clk);
        #2;
        checkQuiet("during reset");
        repeat (3) @(posedge clk);
        #2;
        rst   = 1'b0;  // Reset held for 4 edges
        valid = 1'b0;
        @(posedge clk);
        #2;
        checkQuiet("after reset");
        foreach (rows[i])
        begin
            valid = 1'b1;  // One row per cycle back to back
            funct = rows[i].funct;
            a     = rows[i].a;
            b     = rows[i].b;
            shamt = rows[i].shamt;
            @(posedge clk);
            #2;
            checkRow(i);
        end
        valid = 1'b0;
        @(posedge clk);
        #2;
        checkQuiet("idle cycle");
        errors = DUT.uProps.failures;  // Concurrent assertion failures
        finishTest("bound properties");
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog allows two cycles per row plus margin
    initial
    begin
        wait (tableReady);
        repeat ((rows.size() + 20) * 2) @(posedge clk);
        $display("The run timed out before all tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== tb/execStage_properties.sv ====
`timescale 1ns/10ps

module execStageProperties import aluPkg::*; (
    input logic clk,
    input logic rst,
    input logic valid,
    input logic resultValid,
    input logic writeEnable,
    input logic illegalOp,
    input logic zero,
    input wordT result
);

    int failures = 0;  // Assertion failures so far

    // Nothing comes out of a reset cycle
    validDelay: assert property (@(posedge clk) disable iff (rst)
        resultValid == ($past(valid) && !$past(rst)))
        else
        begin
            $error("resultValid is not valid delayed by one cycle");
            failures++;
        end

    writeNeedsValid: assert property (@(posedge clk) disable iff (rst)
        writeEnable |-> resultValid)
        else
        begin
            $error("writeEnable high without resultValid");
            failures++;
        end

    illegalNoWrite: assert property (@(posedge clk) disable iff (rst)
        illegalOp |-> !writeEnable)  // Illegal code never writes
        else
        begin
            $error("writeEnable high on an illegal operation");
            failures++;
        end

    // Illegal ops clear the zero flag on a zero result
    zeroFlag: assert property (@(posedge clk) disable iff (rst)
        (resultValid && !illegalOp) |-> (zero == (result == '0)))
        else
        begin
            $error("zero flag does not match the result");
            failures++;
        end

endmodule

bind execStage execStageProperties uProps (.*);

// ==== verilog.f ====
+incdir+verilog
verilog/aluPkg.sv
verilog/aluIf.sv
verilog/aluDecoder.sv
verilog/leadingCounter.sv
verilog/barrelShifter.sv
verilog/aluCore.sv
verilog/execStage.sv
tb/execStage_properties.sv
tb/execStageTb.sv

// ==== verilog/aluCore.sv ====
`timescale 1ns/10ps

module aluCore import aluPkg::*; (
    aluReqIf.core  req,
    aluRespIf.core resp
);

    logic [32:0] sum;          // Carry in bit 32
    logic [32:0] diff;         // Borrow in bit 32
    logic        addOvf;
    logic        subOvf;
    logic        ltSigned;
    logic        ltUnsigned;
    logic        varShift;     // Amount taken from a
    logic        shiftRight;
    logic        shiftArith;
    shamtT       shiftAmount;
    wordT        shifted;
    countT       leadCount;
    wordT        resultNext;
    logic        legal;

    // Arithmetic in 33 bits
    assign sum  = {1'b0, req.a} + {1'b0, req.b};
    assign diff = {1'b0, req.a} - {1'b0, req.b};

    // Same-sign operands with a sign flip
    assign addOvf = (req.a[31] == req.b[31]) && (sum[31] != req.a[31]);
    assign subOvf = (req.a[31] != req.b[31]) && (diff[31] != req.a[31]);

    assign ltSigned   = $signed(req.a) < $signed(req.b);
    assign ltUnsigned = diff[32];  // Borrow means a < b

    assign varShift   = (req.op == OP_SLLV) || (req.op == OP_SRLV) || (req.op == OP_SRAV);
    assign shiftRight = (req.op == OP_SRL)  || (req.op == OP_SRA)
                     || (req.op == OP_SRLV) || (req.op == OP_SRAV);
    assign shiftArith = (req.op == OP_SRA)  || (req.op == OP_SRAV);
    assign shiftAmount = varShift ? req.a[$bits(shamtT)-1:0] : req.shamt;

    assign legal = (req.op != OP_ILLEGAL);

    barrelShifter uShifter (
        .data    (req.b),        // Shifts always act on b
        .amount  (shiftAmount),
        .right   (shiftRight),
        .arith   (shiftArith),
        .shifted (shifted)
    );

    leadingCounter uCounter (
        .word      (req.a),
        .countOnes (req.op == OP_CLO),
        .count     (leadCount)
    );

    always_comb
    begin
        resultNext       = '0;
        resp.carry       = 1'b0;
        resp.overflow    = 1'b0;
        resp.writeEnable = 1'b1;  // Most ops write
        case (req.op)
            OP_ADD, OP_ADDU:
            begin
                resultNext    = sum[31:0];
                resp.carry    = sum[32];
                resp.overflow = addOvf;
            end
            OP_SUB, OP_SUBU:
            begin
                resultNext    = diff[31:0];
                resp.carry    = diff[32];  // Borrow
                resp.overflow = subOvf;
            end
            OP_AND:  resultNext = req.a & req.b;
            OP_OR:   resultNext = req.a | req.b;
            OP_XOR:  resultNext = req.a ^ req.b;
            OP_NOR:  resultNext = ~(req.a | req.b);
            OP_SLT:  resultNext = wordT'(ltSigned);
            OP_SLTU: resultNext = wordT'(ltUnsigned);
            OP_SLL, OP_SRL, OP_SRA,
            OP_SLLV, OP_SRLV, OP_SRAV:
                resultNext = shifted;
            OP_CLZ, OP_CLO:
                resultNext = wordT'(leadCount);  // Zero extended
            OP_MOVZ:
            begin
                resultNext       = req.a;
                resp.writeEnable = (req.b == '0);
            end
            OP_MOVN:
            begin
                resultNext       = req.a;
                resp.writeEnable = (req.b != '0);
            end
            default:
                resp.writeEnable = 1'b0;  // Illegal op, everything quiet
        endcase

        resp.result   = resultNext;
        resp.negative = resultNext[31];
        resp.zero     = legal && (resultNext == '0);  // No zero flag on illegal
    end

endmodule

// ==== verilog/aluDecoder.sv ====
`timescale 1ns/10ps

`include "alu_macros.svh"

module aluDecoder import aluPkg::*; (
    input functT          funct,
    aluReqIf.decoder      req
);

    // Function code to operation
    always_comb
    begin
        case (funct)
            `FN_ADD:  req.op = OP_ADD;
            `FN_ADDU: req.op = OP_ADDU;
            `FN_SUB:  req.op = OP_SUB;
            `FN_SUBU: req.op = OP_SUBU;

            // Logic
            `FN_AND:  req.op = OP_AND;
            `FN_OR:   req.op = OP_OR;
            `FN_XOR:  req.op = OP_XOR;
            `FN_NOR:  req.op = OP_NOR;

            `FN_SLT:  req.op = OP_SLT;   // Signed compare
            `FN_SLTU: req.op = OP_SLTU;  // Unsigned compare

            // Shifts
            `FN_SLL:  req.op = OP_SLL;
            `FN_SRL:  req.op = OP_SRL;
            `FN_SRA:  req.op = OP_SRA;
            `FN_SLLV: req.op = OP_SLLV;
            `FN_SRLV: req.op = OP_SRLV;
            `FN_SRAV: req.op = OP_SRAV;

            // Counts
            `FN_CLZ:  req.op = OP_CLZ;
            `FN_CLO:  req.op = OP_CLO;

            `FN_MOVZ: req.op = OP_MOVZ;  // Write when b == 0
            `FN_MOVN: req.op = OP_MOVN;  // Write when b != 0

            default:  req.op = OP_ILLEGAL;
        endcase
    end

endmodule

// ==== verilog/aluIf.sv ====
`timescale 1ns/10ps

// Decoded request into the datapath
interface aluReqIf import aluPkg::*; ();

    aluOpT op;     // From decoder
    wordT  a;      // Operands from the stage inputs
    wordT  b;
    shamtT shamt;  // Fixed shift amount

    modport decoder (
        output op
    );

    modport core (
        input op,
        input a,
        input b,
        input shamt
    );

endinterface

// Combinational response out of the datapath
interface aluRespIf import aluPkg::*; ();

    wordT result;
    logic carry;        // Carry out or borrow
    logic overflow;     // Signed overflow
    logic negative;
    logic zero;
    logic writeEnable;  // Destination write

    modport core (
        output result, carry, overflow, negative, zero, writeEnable
    );

    modport stage (
        input result, carry, overflow, negative, zero, writeEnable
    );

endinterface

// ==== verilog/aluPkg.sv ====
`include "alu_macros.svh"

package aluPkg;

    typedef logic [`DATA_WIDTH-1:0]  wordT;   // Operand and result word
    typedef logic [`FUNCT_WIDTH-1:0] functT;  // Function code
    typedef logic [`SHAMT_WIDTH-1:0] shamtT;  // Shift amount

    // Leading count 0..32 needs one extra bit
    typedef logic [$clog2(`DATA_WIDTH+1)-1:0] countT;

    // Decoded operation
    typedef enum logic [4:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,      // Shift by shamt
        OP_SLLV, OP_SRLV, OP_SRAV,   // Shift by a[4:0]
        OP_CLZ, OP_CLO,
        OP_MOVZ, OP_MOVN,
        OP_ILLEGAL                   // Unknown function code
    } aluOpT;

endpackage

// ==== verilog/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define DATA_WIDTH  32  // One operand word
`define FUNCT_WIDTH 6   // R-type function field
`define SHAMT_WIDTH 5   // Shift amount field

// R-type function codes
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_SRA   6'b000011
`define FN_SLLV  6'b000100
`define FN_SRLV  6'b000110
`define FN_SRAV  6'b000111
`define FN_MOVZ  6'b001010
`define FN_MOVN  6'b001011
`define FN_CLO   6'b011100  // Count leading ones
`define FN_CLZ   6'b011101  // Count leading zeros
`define FN_ADD   6'b100000
`define FN_ADDU  6'b100001
`define FN_SUB   6'b100010
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_NOR   6'b100111
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

`endif

// ==== verilog/barrelShifter.sv ====
`timescale 1ns/10ps

module barrelShifter import aluPkg::*; (
    input  wordT  data,
    input  shamtT amount,
    input  logic  right,   // Right shift when set
    input  logic  arith,   // Sign fill on right shifts
    output wordT  shifted
);

    logic fill;
    wordT stage16;
    wordT stage8;
    wordT stage4;
    wordT stage2;

    assign fill = arith & data[31];  // Only meaningful when right

    // One stage per amount bit, largest first
    always_comb
    begin
        if (!amount[4])  stage16 = data;
        else if (right)  stage16 = {{16{fill}}, data[31:16]};
        else             stage16 = {data[15:0], 16'b0};

        if (!amount[3])  stage8 = stage16;
        else if (right)  stage8 = {{8{fill}}, stage16[31:8]};
        else             stage8 = {stage16[23:0], 8'b0};

        if (!amount[2])  stage4 = stage8;
        else if (right)  stage4 = {{4{fill}}, stage8[31:4]};
        else             stage4 = {stage8[27:0], 4'b0};

        if (!amount[1])  stage2 = stage4;
        else if (right)  stage2 = {{2{fill}}, stage4[31:2]};
        else             stage2 = {stage4[29:0], 2'b0};

        if (!amount[0])  shifted = stage2;
        else if (right)  shifted = {fill, stage2[31:1]};
        else             shifted = {stage2[30:0], 1'b0};
    end

endmodule

// ==== verilog/execStage.sv ====
`timescale 1ns/10ps

module execStage import aluPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  valid,        // Request strobe
    input  functT funct,
    input  wordT  a,
    input  wordT  b,
    input  shamtT shamt,
    output logic  resultValid,  // One cycle after valid
    output logic  writeEnable,
    output logic  carry,
    output logic  overflow,
    output logic  negative,
    output logic  zero,
    output logic  illegalOp,
    output wordT  result
);

    aluReqIf  reqBus ();
    aluRespIf respBus ();

    // Operands straight onto the request bus
    assign reqBus.a     = a;
    assign reqBus.b     = b;
    assign reqBus.shamt = shamt;

    aluDecoder uDecoder (
        .funct (funct),
        .req   (reqBus.decoder)
    );

    aluCore uCore (
        .req  (reqBus.core),
        .resp (respBus.core)
    );

    // Output register, one item per cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            resultValid <= 1'b0;
            writeEnable <= 1'b0;
            carry       <= 1'b0;
            overflow    <= 1'b0;
            negative    <= 1'b0;
            zero        <= 1'b0;
            illegalOp   <= 1'b0;
            result      <= '0;
        end
        else
        begin
            resultValid <= valid;
            writeEnable <= valid && respBus.writeEnable;  // Drops on idle cycle
            if (valid)
            begin
                carry     <= respBus.carry;
                overflow  <= respBus.overflow;
                negative  <= respBus.negative;
                zero      <= respBus.zero;
                illegalOp <= (reqBus.op == OP_ILLEGAL);
                result    <= respBus.result;
            end
        end
    end

endmodule

// ==== verilog/leadingCounter.sv ====
`timescale 1ns/10ps

module leadingCounter import aluPkg::*; (
    input  wordT  word,
    input  logic  countOnes,  // CLO when set
    output countT count
);

    wordT searchWord;

    // Leading ones become leading zeros
    assign searchWord = countOnes ? ~word : word;

    // Priority search for the highest one bit
    always_comb
    begin
        count = countT'($bits(wordT));  // All zero gives 32
        for (int i = 0; i < $bits(wordT); i++)
        begin
            if (searchWord[i])
            begin
                count = countT'($bits(wordT) - 1 - i);  // Higher bits override
            end
        end
    end

endmodule
